/* tests/dotp_golden.txt */
// Columns: kind addr data strb resp, kind 1 write, 2 read, 3 wait engine done, 4 read while busy
// data is write data or expected read data; resp 0 OKAY, 2 SLVERR
1 00000100 a5a5a5a5 f 0
2 00000100 a5a5a5a5 0 0
1 00000100 00003c00 2 0
2 00000100 a5a53ca5 0 0
1 00000000 00020001 f 0
1 00000004 00040003 f 0
1 00000008 ffff0005 f 0
1 0000000c 80007fff f 0
1 00000010 00060005 f 0
1 00000014 00080007 f 0
1 00000018 0003fffe f 0
1 0000001c 80007fff f 0
2 00000000 00020001 0 0
2 0000000c 80007fff 0 0
1 00002000 12345678 f 2
2 00002000 00000000 0 2
1 00001100 00000001 f 2
2 00000100 a5a53ca5 0 0
1 00001004 00000000 f 0
1 00001008 00000010 f 0
1 0000100c 00000020 f 0
1 00001010 00000004 f 0
1 00001000 00000001 f 0
4 00000004 00040003 0 0
4 00000018 0003fffe 0 0
3 00000000 00000000 0 0
2 00001014 7fff003a 0 0
2 00000020 7fff003a 0 0
2 00001000 00000000 0 0
1 00000024 deadbeef f 0
1 0000100c 00000024 f 0
1 00001010 00000000 f 0
1 00001000 00000001 f 0
3 00000000 00000000 0 0
2 00001014 00000000 0 0
2 00000024 00000000 0 0

/* build.f */
logic/tile_cfg_pkg.sv
logic/tile_data_pkg.sv
logic/tile_bus_if.sv
logic/axil_host_port.sv
logic/dotp_engine.sv
logic/l1_arbiter.sv
logic/l1_spm.sv
logic/dotp_tile.sv
tests/tb_dotp_tile.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the tile testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module tb_dotp_tile -f build.f > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Compilation failed"
  exit 1
fi

./obj_dir/Vtb_dotp_tile > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Test FAILED" sim.log; then
  exit 1
fi
exit 0

/* tests/tb_dotp_tile.sv */
// ----------------------------------------------------------------------
// Dot-product tile testbench
// Replays AXI4-Lite transactions from a golden file, checks responses,
// engine status pulses and response stability under back-pressure
// ----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_dotp_tile;
  import tile_cfg_pkg::*;
  import tile_data_pkg::*;

  localparam int unsigned MAX_TXN   = 64;   // Golden lines at most
  localparam int unsigned N_COL     = 5;    // kind addr data strb resp
  localparam int unsigned HS_TMO    = 100;  // Cycles for one bus wait
  localparam int unsigned ENG_TMO   = 2000; // Cycles for one engine run

  logic              clk_i, rstn_i;
  logic              s_awvalid_i, s_awready_o, s_wvalid_i, s_wready_o;
  logic [ADDR_W-1:0] s_awaddr_i, s_araddr_i;
  logic [DATA_W-1:0] s_wdata_i, s_rdata_o;
  logic [STRB_W-1:0] s_wstrb_i;
  logic              s_bvalid_o, s_bready_i, s_arvalid_i, s_arready_o;
  logic              s_rvalid_o, s_rready_i, busy_o, evt_o;
  logic [1:0]        s_bresp_o, s_rresp_o;

  logic [31:0] golden [MAX_TXN*N_COL];
  logic [31:0] lcg_state;
  int unsigned checks, value_errs, other_errs;
  int unsigned busy_rises, evt_pulses, runs_expected;
  logic        busy_prev;
  bit          abort;

  dotp_tile #(.N_BANKS(4), .N_WORDS_BANK(256)) i_dotp_tile (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;                                   // 10 ns period
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, act);
    checks++;
    assert (act === exp) else begin
      value_errs++;
      $display("ERROR at %0t ns: %s expected 0x%08h, actual 0x%08h", $time, name, exp, act);
    end
  endtask

  task automatic check_true(input bit cond, input string msg);
    checks++;
    assert (cond) else begin
      other_errs++;
      $display("FAILURE at %0t ns: %s", $time, msg);
    end
  endtask

  // One AXI4-Lite transfer; ready held low for 0 to 3 random cycles
  task automatic do_access(input bit is_write, input logic [31:0] addr, wdata,
                           input logic [3:0] strb,
                           output logic [31:0] rdata, output logic [1:0] resp);
    int unsigned t;
    int unsigned idle;
    bit          hs;
    @(negedge clk_i);
    if (is_write) begin
      s_awvalid_i = 1'b1;
      s_awaddr_i  = addr;
      s_wvalid_i  = 1'b1;
      s_wdata_i   = wdata;
      s_wstrb_i   = strb;
    end else begin
      s_arvalid_i = 1'b1;
      s_araddr_i  = addr;
    end
    hs = 1'b0;
    t  = 0;
    while (!hs && t < HS_TMO) begin
      #1;                                                        // Let ready settle
      hs = is_write ? (s_awready_o && s_wready_o) : s_arready_o;
      @(negedge clk_i);
      t++;
    end
    s_awvalid_i = 1'b0;
    s_wvalid_i  = 1'b0;
    s_arvalid_i = 1'b0;
    if (!hs) begin
      check_true(1'b0, "address was never accepted by the host port");
      abort = 1'b1;
      return;
    end
    t = 0;
    while (!(is_write ? s_bvalid_o : s_rvalid_o) && t < HS_TMO) begin
      @(negedge clk_i);
      t++;
    end
    if (!(is_write ? s_bvalid_o : s_rvalid_o)) begin
      check_true(1'b0, "no response came back from the host port");
      abort = 1'b1;
      return;
    end
    rdata = s_rdata_o;
    resp  = is_write ? s_bresp_o : s_rresp_o;
    idle  = (lcg_next() >> 16) % 4;
    repeat (idle) begin
      @(negedge clk_i);
      check_true(is_write ? s_bvalid_o : s_rvalid_o, "response valid dropped before ready");
      check_true((is_write ? s_bresp_o : s_rresp_o) == resp && (is_write || s_rdata_o == rdata),
                 "response payload changed before ready");
    end
    if (is_write) s_bready_i = 1'b1;
    else          s_rready_i = 1'b1;
    @(negedge clk_i);                                            // Beat taken at posedge
    s_bready_i = 1'b0;
    s_rready_i = 1'b0;
  endtask

  // Engine status watch, evt_o must pulse exactly as busy_o falls
  always @(negedge clk_i) begin
    if (!rstn_i) begin
      busy_prev = 1'b0;
    end else begin
      if (busy_o && !busy_prev) busy_rises++;
      if (evt_o) evt_pulses++;
      check_true(evt_o == (busy_prev && !busy_o), "evt_o pulse not aligned with busy_o falling");
      busy_prev = busy_o;
    end
  end

  initial begin
    logic [31:0] kind, addr, data, rd;
    logic [3:0]  strb;
    logic [1:0]  exp_resp, resp;
    int unsigned t;
    rstn_i = 1'b0;
    s_awvalid_i = 1'b0;
    s_awaddr_i  = '0;
    s_wvalid_i  = 1'b0;
    s_wdata_i   = '0;
    s_wstrb_i   = '0;
    s_bready_i  = 1'b0;
    s_arvalid_i = 1'b0;
    s_araddr_i  = '0;
    s_rready_i  = 1'b0;
    lcg_state   = 32'd87836;                                     // Fixed seed
    checks = 0;
    value_errs = 0;
    other_errs = 0;
    busy_rises = 0;
    evt_pulses = 0;
    runs_expected = 0;
    abort = 1'b0;
    for (int i = 0; i < MAX_TXN*N_COL; i++) golden[i] = '0;      // Kind 0 ends the list
    $readmemh("tests/dotp_golden.txt", golden);
    check_true(golden[0] != '0, "golden file is empty or missing");
    repeat (4) @(negedge clk_i);
    rstn_i = 1'b1;
    check_true(!busy_o && !evt_o && !s_bvalid_o && !s_rvalid_o && !s_arready_o
               && !s_awready_o && !s_wready_o, "outputs not idle after reset");
    for (int i = 0; i < MAX_TXN && !abort; i++) begin
      kind     = golden[N_COL*i];
      addr     = golden[N_COL*i+1];
      data     = golden[N_COL*i+2];
      strb     = golden[N_COL*i+3][3:0];
      exp_resp = golden[N_COL*i+4][1:0];
      if (kind == '0) break;
      case (kind)
        32'd1: begin
          do_access(1'b1, addr, data, strb, rd, resp);
          if (!abort) check_value("s_bresp_o", 32'(exp_resp), 32'(resp));
        end
        32'd2, 32'd4: begin
          if (kind == 32'd4) check_true(busy_o, "engine was idle when the overlapped read began");
          do_access(1'b0, addr, '0, '0, rd, resp);
          if (!abort) begin
            check_value("s_rdata_o", data, rd);
            check_value("s_rresp_o", 32'(exp_resp), 32'(resp));
          end
        end
        32'd3: begin
          runs_expected++;
          t = 0;
          while ((busy_o || evt_pulses < runs_expected) && t < ENG_TMO) begin
            @(negedge clk_i);
            t++;
          end
          check_true(t < ENG_TMO, "engine did not finish in time");
          check_value("busy_o rises", 32'(runs_expected), 32'(busy_rises));
          check_value("evt_o pulses", 32'(runs_expected), 32'(evt_pulses));
        end
        default: check_true(1'b0, "unknown transaction kind in golden file");
      endcase
    end
    repeat (2) @(negedge clk_i);
    $display("Summary: %0d checks, %0d value errors, %0d other errors",
             checks, value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* logic/dotp_tile.sv */
// ------------------------------------------------------------------
// Dot-product tile top level
// AXI4-Lite host port and engine sharing a banked L1 scratchpad
// ------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module dotp_tile #(
  parameter int unsigned N_BANKS      = 4,   // Scratchpad banks
  parameter int unsigned N_WORDS_BANK = 256  // Words per bank
) (
  input  logic                             clk_i,
  input  logic                             rstn_i,
  input  logic                             s_awvalid_i,
  output logic                             s_awready_o,
  input  logic [tile_cfg_pkg::ADDR_W-1:0]  s_awaddr_i,
  input  logic                             s_wvalid_i,
  output logic                             s_wready_o,
  input  logic [tile_data_pkg::DATA_W-1:0] s_wdata_i,
  input  logic [tile_data_pkg::STRB_W-1:0] s_wstrb_i,
  output logic                             s_bvalid_o,
  input  logic                             s_bready_i,
  output logic [1:0]                       s_bresp_o,
  input  logic                             s_arvalid_i,
  output logic                             s_arready_o,
  input  logic [tile_cfg_pkg::ADDR_W-1:0]  s_araddr_i,
  output logic                             s_rvalid_o,
  input  logic                             s_rready_i,
  output logic [tile_data_pkg::DATA_W-1:0] s_rdata_o,
  output logic [1:0]                       s_rresp_o,
  output logic                             busy_o,
  output logic                             evt_o
);

  mem_bus_if host_bus ();  // Host port to arbiter
  mem_bus_if eng_bus ();   // Engine to arbiter
  mem_bus_if spm_bus ();   // Arbiter to scratchpad
  cfg_reg_if cfg_bus ();   // Host port to engine registers

  axil_host_port #(
    .N_BANKS      ( N_BANKS      ),
    .N_WORDS_BANK ( N_WORDS_BANK )
  ) i_axil_host_port (
    .clk_i, .rstn_i,
    .s_awvalid_i, .s_awready_o, .s_awaddr_i,
    .s_wvalid_i, .s_wready_o, .s_wdata_i, .s_wstrb_i,
    .s_bvalid_o, .s_bready_i, .s_bresp_o,
    .s_arvalid_i, .s_arready_o, .s_araddr_i,
    .s_rvalid_o, .s_rready_i, .s_rdata_o, .s_rresp_o,
    .mem_o ( host_bus ),
    .cfg_o ( cfg_bus  )
  );

  dotp_engine i_dotp_engine (
    .clk_i, .rstn_i,
    .cfg_i  ( cfg_bus ),
    .mem_o  ( eng_bus ),
    .busy_o,
    .evt_o
  );

  l1_arbiter #(
    .N_BANKS      ( N_BANKS      ),
    .N_WORDS_BANK ( N_WORDS_BANK )
  ) i_l1_arbiter (
    .clk_i, .rstn_i,
    .host_i ( host_bus ),
    .eng_i  ( eng_bus  ),
    .spm_o  ( spm_bus  )
  );

  l1_spm #(
    .N_BANKS      ( N_BANKS      ),
    .N_WORDS_BANK ( N_WORDS_BANK )
  ) i_l1_spm (
    .clk_i, .rstn_i,
    .bus_i ( spm_bus )
  );

endmodule

`default_nettype wire

/* logic/l1_spm.sv */
// ------------------------------------------------------------------
// L1 scratchpad
// Word-interleaved single-port banks, read data one cycle after grant
// ------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module l1_spm #(
  parameter int unsigned N_BANKS      = 4,
  parameter int unsigned N_WORDS_BANK = 256
) (
  input  logic           clk_i,
  input  logic           rstn_i,
  mem_bus_if.subordinate bus_i
);
  import tile_data_pkg::*;

  localparam int unsigned BANK_W = $clog2(N_BANKS);
  localparam int unsigned ROW_W  = $clog2(N_WORDS_BANK);

  logic [BANK_W-1:0] bank, bank_q;
  logic [ROW_W-1:0]  row;
  logic [DATA_W-1:0] bank_rdata [N_BANKS];
  logic              rvalid_q;

  assign bank      = bus_i.addr[2 +: BANK_W];                          // Low word bits
  assign row       = bus_i.addr[2+BANK_W +: ROW_W];
  assign bus_i.gnt = 1'b1;                                             // Never stalls

  for (genvar b = 0; b < N_BANKS; b++) begin : g_bank
    logic [DATA_W-1:0] mem_q [N_WORDS_BANK];
    logic [DATA_W-1:0] rd_q;
    always_ff @(posedge clk_i) begin
      if (bus_i.req && bank == BANK_W'(b)) begin
        if (bus_i.we) begin
          for (int i = 0; i < STRB_W; i++) begin
            if (bus_i.be[i]) mem_q[row][8*i +: 8] <= bus_i.wdata.raw[8*i +: 8];
          end
        end else begin
          rd_q <= mem_q[row];
        end
      end
    end
    assign bank_rdata[b] = rd_q;
  end

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) rvalid_q <= 1'b0;
    else         rvalid_q <= bus_i.req;                                // Reads and writes
  end

  always_ff @(posedge clk_i) begin
    if (bus_i.req) bank_q <= bank;
  end

  assign bus_i.rvalid    = rvalid_q;
  assign bus_i.rdata.raw = bank_rdata[bank_q];

endmodule

`default_nettype wire

/* logic/l1_arbiter.sv */
// ------------------------------------------------------------------
// L1 arbiter
// Round-robin between host and engine onto the scratchpad bus
// ------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module l1_arbiter #(
  parameter int unsigned N_BANKS      = 4,
  parameter int unsigned N_WORDS_BANK = 256
) (
  input  logic           clk_i,
  input  logic           rstn_i,
  mem_bus_if.subordinate host_i,
  mem_bus_if.subordinate eng_i,
  mem_bus_if.manager     spm_o
);
  import tile_cfg_pkg::*;

  localparam logic [ADDR_W-3:0] L1_WORDS = (ADDR_W-2)'(N_BANKS * N_WORDS_BANK);

  logic prio_q, last_q, host_win, eng_win, addr_oob;

  assign host_win = host_i.req && (!eng_i.req || !prio_q);             // prio_q set favors engine
  assign eng_win  = eng_i.req && !host_win;

  assign spm_o.req   = host_win || eng_win;
  assign spm_o.we    = eng_win ? eng_i.we    : host_i.we;
  assign spm_o.addr  = eng_win ? eng_i.addr  : host_i.addr;
  assign spm_o.wdata = eng_win ? eng_i.wdata : host_i.wdata;
  assign spm_o.be    = eng_win ? eng_i.be    : host_i.be;

  assign host_i.gnt    = host_win && spm_o.gnt;
  assign eng_i.gnt     = eng_win && spm_o.gnt;
  assign host_i.rvalid = spm_o.rvalid && !last_q;                      // Route by last grant
  assign eng_i.rvalid  = spm_o.rvalid && last_q;
  assign host_i.rdata  = spm_o.rdata;
  assign eng_i.rdata   = spm_o.rdata;

  assign addr_oob = spm_o.req && (spm_o.addr[ADDR_W-1:2] >= L1_WORDS);

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      prio_q <= 1'b0;                                                  // Host first
      last_q <= 1'b0;
    end else if (spm_o.req && spm_o.gnt) begin
      last_q <= eng_win;
      if (host_i.req && eng_i.req) prio_q <= host_win;                 // Alternate on conflict
    end
  end

  // Each granted transfer is answered on exactly one side a cycle later
  a_rsp_onehot: assert property (@(posedge clk_i) disable iff (!rstn_i)
    spm_o.req && spm_o.gnt |=> $onehot({host_i.rvalid, eng_i.rvalid}));
  a_addr_in_l1: assert property (@(posedge clk_i) disable iff (!rstn_i) !addr_oob);

endmodule

`default_nettype wire

/* logic/dotp_engine.sv */
// ------------------------------------------------------------------
// Dot-product engine
// Config registers and a sequencer that reads two vectors from L1,
// sums the element products and writes the sum back
// ------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module dotp_engine (
  input  logic      clk_i,
  input  logic      rstn_i,
  cfg_reg_if.target cfg_i,
  mem_bus_if.manager mem_o,
  output logic      busy_o,
  output logic      evt_o
);
  import tile_cfg_pkg::*;
  import tile_data_pkg::*;

  typedef enum logic [2:0] {ST_IDLE, ST_FETCH_A, ST_FETCH_B, ST_ACC, ST_WRITE} state_e;

  state_e                   state_q;
  logic                     pend_q, evt_q, start;
  logic [ADDR_W-1:0]        src_a_q, src_b_q, dst_q, offs;
  logic [DATA_W-1:0]        len_q, idx_q, rdata_q;
  logic [ACC_W-1:0]         acc_q, result_q;
  logic signed [ACC_W-1:0]  prod0, prod1;
  vec_word_u                a_q, b_q;

  // CTRL write while busy is dropped
  assign start = cfg_i.req && cfg_i.we && (cfg_i.addr == REG_CTRL) && cfg_i.wdata[0]
                 && (state_q == ST_IDLE);

  assign offs  = {idx_q[ADDR_W-3:0], 2'b00};                          // Word index to bytes
  assign prod0 = $signed(a_q.elem.e0) * $signed(b_q.elem.e0);
  assign prod1 = $signed(a_q.elem.e1) * $signed(b_q.elem.e1);

  assign mem_o.req       = (state_q inside {ST_FETCH_A, ST_FETCH_B, ST_WRITE}) && !pend_q;
  assign mem_o.we        = (state_q == ST_WRITE);
  assign mem_o.addr      = (state_q == ST_WRITE)   ? dst_q :
                           (state_q == ST_FETCH_B) ? src_b_q + offs : src_a_q + offs;
  assign mem_o.wdata.raw = acc_q;
  assign mem_o.be        = '1;                                         // Full word result

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      state_q  <= ST_IDLE;
      pend_q   <= 1'b0;
      evt_q    <= 1'b0;
      src_a_q  <= '0;
      src_b_q  <= '0;
      dst_q    <= '0;
      len_q    <= '0;
      idx_q    <= '0;
      acc_q    <= '0;
      result_q <= '0;
      rdata_q  <= '0;
    end else begin
      evt_q <= 1'b0;
      if (cfg_i.req && cfg_i.we) begin
        case (cfg_i.addr)
          REG_SRC_A: src_a_q <= cfg_i.wdata;
          REG_SRC_B: src_b_q <= cfg_i.wdata;
          REG_DST:   dst_q   <= cfg_i.wdata;
          REG_LEN:   len_q   <= cfg_i.wdata;
          default: ;                                                   // CTRL, RESULT
        endcase
      end
      if (cfg_i.req && !cfg_i.we) begin
        case (cfg_i.addr)
          REG_CTRL:   rdata_q <= {{(DATA_W-1){1'b0}}, busy_o};
          REG_SRC_A:  rdata_q <= src_a_q;
          REG_SRC_B:  rdata_q <= src_b_q;
          REG_DST:    rdata_q <= dst_q;
          REG_LEN:    rdata_q <= len_q;
          REG_RESULT: rdata_q <= result_q;
          default:    rdata_q <= '0;
        endcase
      end
      case (state_q)
        ST_IDLE: if (start) begin
          acc_q   <= '0;
          idx_q   <= '0;
          state_q <= (len_q == '0) ? ST_WRITE : ST_FETCH_A;            // Empty vector
        end
        ST_FETCH_A, ST_FETCH_B, ST_WRITE: begin
          if (mem_o.req && mem_o.gnt) pend_q <= 1'b1;                  // Wait for rvalid
          if (mem_o.rvalid) begin
            pend_q <= 1'b0;
            if (state_q == ST_FETCH_A) state_q <= ST_FETCH_B;
            else if (state_q == ST_FETCH_B) state_q <= ST_ACC;
            else begin
              result_q <= acc_q;
              evt_q    <= 1'b1;                                        // Done as busy falls
              state_q  <= ST_IDLE;
            end
          end
        end
        ST_ACC: begin
          acc_q   <= acc_q + prod0 + prod1;                            // Wraps at ACC_W
          idx_q   <= idx_q + 1'b1;
          state_q <= (idx_q + 1'b1 == len_q) ? ST_WRITE : ST_FETCH_A;
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (mem_o.rvalid && state_q == ST_FETCH_A) a_q <= mem_o.rdata;
    if (mem_o.rvalid && state_q == ST_FETCH_B) b_q <= mem_o.rdata;
  end

  assign cfg_i.rdata = rdata_q;
  assign busy_o      = (state_q != ST_IDLE);
  assign evt_o       = evt_q;

  // Idle engine neither requests nor gets responses routed to it
  a_idle_quiet: assert property (@(posedge clk_i) disable iff (!rstn_i)
    !busy_o |-> !mem_o.req && !mem_o.rvalid);

endmodule

`default_nettype wire

/* logic/axil_host_port.sv */
// ------------------------------------------------------------------
// AXI4-Lite host port
// Takes one transaction at a time and decodes it to L1, the engine
// registers or an unmapped region that answers SLVERR
// ------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module axil_host_port #(
  parameter int unsigned N_BANKS      = 4,
  parameter int unsigned N_WORDS_BANK = 256
) (
  input  logic                             clk_i,
  input  logic                             rstn_i,
  input  logic                             s_awvalid_i,
  output logic                             s_awready_o,
  input  logic [tile_cfg_pkg::ADDR_W-1:0]  s_awaddr_i,
  input  logic                             s_wvalid_i,
  output logic                             s_wready_o,
  input  logic [tile_data_pkg::DATA_W-1:0] s_wdata_i,
  input  logic [tile_data_pkg::STRB_W-1:0] s_wstrb_i,
  output logic                             s_bvalid_o,
  input  logic                             s_bready_i,
  output logic [1:0]                       s_bresp_o,
  input  logic                             s_arvalid_i,
  output logic                             s_arready_o,
  input  logic [tile_cfg_pkg::ADDR_W-1:0]  s_araddr_i,
  output logic                             s_rvalid_o,
  input  logic                             s_rready_i,
  output logic [tile_data_pkg::DATA_W-1:0] s_rdata_o,
  output logic [1:0]                       s_rresp_o,
  mem_bus_if.manager                       mem_o,
  cfg_reg_if.host                          cfg_o
);
  import tile_cfg_pkg::*;
  import tile_data_pkg::*;

  localparam logic [ADDR_W-1:0] L1_BYTES = ADDR_W'(N_BANKS * N_WORDS_BANK * STRB_W);

  typedef enum logic [2:0] {ST_IDLE, ST_MEM, ST_MWAIT, ST_WAIT, ST_RESP} state_e;

  state_e            state_q;
  logic              ar_hs, aw_hs;
  logic [ADDR_W-1:0] acc_addr;
  logic              in_l1, in_reg;
  logic              we_q, err_q, bvalid_q, rvalid_q;
  logic [1:0]        resp_q;
  logic [ADDR_W-1:0] addr_q;
  logic [DATA_W-1:0] wdata_q, rdata_q;
  logic [STRB_W-1:0] strb_q;

  assign s_arready_o = (state_q == ST_IDLE) && s_arvalid_i;            // Read wins
  assign s_awready_o = (state_q == ST_IDLE) && !s_arvalid_i && s_awvalid_i && s_wvalid_i;
  assign s_wready_o  = s_awready_o;                                    // AW and W together
  assign ar_hs       = s_arvalid_i && s_arready_o;
  assign aw_hs       = s_awvalid_i && s_awready_o;

  assign acc_addr = ar_hs ? s_araddr_i : s_awaddr_i;
  assign in_l1    = (acc_addr >= L1_BASE) && (acc_addr - L1_BASE < L1_BYTES);
  assign in_reg   = (acc_addr >= REG_BASE) && (acc_addr - REG_BASE < REG_SPAN);

  // Register access issued in the accept cycle, data back one cycle later
  assign cfg_o.req   = (ar_hs || aw_hs) && in_reg;
  assign cfg_o.we    = aw_hs;
  assign cfg_o.addr  = acc_addr[2 +: REG_AW];                          // Word offset
  assign cfg_o.wdata = s_wdata_i;

  assign mem_o.req       = (state_q == ST_MEM);                        // Held until gnt
  assign mem_o.we        = we_q;
  assign mem_o.addr      = addr_q - L1_BASE;                           // Offset into L1
  assign mem_o.wdata.raw = wdata_q;
  assign mem_o.be        = strb_q;

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      state_q  <= ST_IDLE;
      we_q     <= 1'b0;
      err_q    <= 1'b0;
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
      resp_q   <= RESP_OKAY;
    end else begin
      case (state_q)
        ST_IDLE: if (ar_hs || aw_hs) begin
          we_q    <= aw_hs;
          err_q   <= !in_l1 && !in_reg;                                // Unmapped
          state_q <= in_l1 ? ST_MEM : ST_WAIT;
        end
        ST_MEM: if (mem_o.gnt) state_q <= ST_MWAIT;
        ST_MWAIT, ST_WAIT: if (state_q == ST_WAIT || mem_o.rvalid) begin
          resp_q   <= err_q ? RESP_SLVERR : RESP_OKAY;
          bvalid_q <= we_q;
          rvalid_q <= !we_q;
          state_q  <= ST_RESP;
        end
        ST_RESP: if ((bvalid_q && s_bready_i) || (rvalid_q && s_rready_i)) begin
          bvalid_q <= 1'b0;
          rvalid_q <= 1'b0;
          state_q  <= ST_IDLE;                                         // Next address now
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (ar_hs || aw_hs) begin
      addr_q  <= acc_addr;
      wdata_q <= s_wdata_i;
      strb_q  <= s_wstrb_i;
    end
    if (state_q == ST_WAIT) rdata_q <= err_q ? '0 : cfg_o.rdata;       // Zero on error
    else if (state_q == ST_MWAIT && mem_o.rvalid) rdata_q <= mem_o.rdata.raw;
  end

  assign s_bvalid_o = bvalid_q;
  assign s_bresp_o  = resp_q;
  assign s_rvalid_o = rvalid_q;
  assign s_rresp_o  = resp_q;
  assign s_rdata_o  = rdata_q;

  // A held response keeps its payload until the manager takes it
  a_b_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
    s_bvalid_o && !s_bready_i |=> s_bvalid_o && $stable(s_bresp_o));
  a_r_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
    s_rvalid_o && !s_rready_i |=> s_rvalid_o && $stable(s_rresp_o) && $stable(s_rdata_o));

endmodule

`default_nettype wire

/* logic/tile_bus_if.sv */
// ------------------------------------------------------------------
// Tile bus interfaces
// L1 memory request/grant bus and engine configuration register bus
// ------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

interface mem_bus_if;

  logic                                req;    // Request, held until gnt
  logic                                we;     // Write enable
  logic [tile_cfg_pkg::ADDR_W-1:0]     addr;   // Byte address inside L1
  tile_data_pkg::vec_word_u            wdata;
  logic [tile_data_pkg::STRB_W-1:0]    be;     // Byte enables
  logic                                gnt;    // Transfer when req and gnt
  logic                                rvalid; // One cycle after each transfer
  tile_data_pkg::vec_word_u            rdata;  // Undefined after a write

  modport manager     (output req, we, addr, wdata, be, input  gnt, rvalid, rdata);
  modport subordinate (input  req, we, addr, wdata, be, output gnt, rvalid, rdata);

endinterface

interface cfg_reg_if;

  logic                              req;   // Always accepted
  logic                              we;
  logic [tile_cfg_pkg::REG_AW-1:0]   addr;  // Word offset inside the window
  logic [tile_data_pkg::DATA_W-1:0]  wdata;
  logic [tile_data_pkg::DATA_W-1:0]  rdata; // Valid one cycle after req

  modport host   (output req, we, addr, wdata, input  rdata);
  modport target (input  req, we, addr, wdata, output rdata);

endinterface

`default_nettype wire

/* logic/tile_data_pkg.sv */
// ------------------------------------------------------------------
// Tile datapath package
// Word and element widths, and the two views of one data word
// ------------------------------------------------------------------
`default_nettype none

package tile_data_pkg;

  parameter int unsigned DATA_W = 32;         // Data word width
  parameter int unsigned STRB_W = DATA_W / 8; // One enable per byte
  parameter int unsigned ELEM_W = 16;         // Vector element width
  parameter int unsigned ACC_W  = 32;         // Wrapping accumulator width

  // Element pair as seen by the engine, element 0 in the low half
  typedef struct packed {
    logic signed [ELEM_W-1:0] e1;
    logic signed [ELEM_W-1:0] e0;
  } elem_pair_t;

  // Raw word for host and scratchpad, element pair for the engine
  typedef union packed {
    logic [DATA_W-1:0] raw;
    elem_pair_t        elem;
  } vec_word_u;

endpackage

`default_nettype wire

/* logic/tile_cfg_pkg.sv */
// ------------------------------------------------------------------
// Tile configuration package
// Memory map, engine register offsets and AXI4-Lite response codes
// ------------------------------------------------------------------
`default_nettype none

package tile_cfg_pkg;

  parameter int unsigned       ADDR_W   = 32;            // Byte address width
  parameter logic [ADDR_W-1:0] L1_BASE  = 32'h0000_0000; // Scratchpad window base
  parameter logic [ADDR_W-1:0] REG_BASE = 32'h0000_1000; // Engine register window base
  parameter logic [ADDR_W-1:0] REG_SPAN = 32'h0000_0100; // Register window size in bytes
  parameter int unsigned       REG_AW   = $clog2(REG_SPAN / 4); // Word offset width

  // Word offsets inside the register window
  parameter logic [REG_AW-1:0] REG_CTRL   = REG_AW'(0); // W: bit 0 start, R: bit 0 busy
  parameter logic [REG_AW-1:0] REG_SRC_A  = REG_AW'(1); // Vector A byte address
  parameter logic [REG_AW-1:0] REG_SRC_B  = REG_AW'(2); // Vector B byte address
  parameter logic [REG_AW-1:0] REG_DST    = REG_AW'(3); // Result byte address
  parameter logic [REG_AW-1:0] REG_LEN    = REG_AW'(4); // Vector length in words
  parameter logic [REG_AW-1:0] REG_RESULT = REG_AW'(5); // Last sum, read only

  parameter logic [1:0] RESP_OKAY   = 2'b00;
  parameter logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire
